//--- source/gbf_defines.svh
`ifndef GBF_DEFINES_SVH
`define GBF_DEFINES_SVH

// **********************************************************************
// Weight buffer geometry
// **********************************************************************
// Buffer address width, 64 words
`define GBF_ADDR_BITS 6
`define GBF_DEPTH (1 << `GBF_ADDR_BITS)
// One reserved bit, three flags, three 8-bit weights
`define GBF_WORD_BITS 28

// **********************************************************************
// APB register map
// **********************************************************************
`define GBF_APB_ADDR_BITS 12
`define GBF_REG_CTRL 12'h000
`define GBF_REG_STATUS 12'h004
// Buffer window, word i at base + 4*i
`define GBF_BUF_BASE 12'h100

`endif

//--- source/gbf_pkg.sv
`include "gbf_defines.svh"

package gbf_pkg;

    // Field view of one buffer word
    // Lane 0 in the low byte, flag bit k gates lane k
    typedef struct packed {
        logic            rsvd;
        logic [2:0]      flags;
        logic [2:0][7:0] lanes;
    } gbf_word_fields_s;

    // Same word as written over APB and as walked by the decoder
    typedef union packed {
        logic [`GBF_WORD_BITS-1:0] raw;
        gbf_word_fields_s          fields;
    } gbf_word_u;

    // One kept weight on the output stream
    // Position is word index * 3 + lane
    typedef struct packed {
        logic signed [7:0] weight;
        logic [7:0]        pos;
    } gbf_weight_s;

    // Decoder status, count saturates at 127
    typedef struct packed {
        logic       busy;
        logic [6:0] count;
    } gbf_status_s;

endpackage

//--- source/gbf_weight_sram.sv
`timescale 1ns/1ns
`include "gbf_defines.svh"

module gbf_weight_sram (
    input  logic                      clk,
    input  logic                      read_en,
    input  logic                      write_en,
    input  logic [`GBF_ADDR_BITS-1:0] addr_r,
    input  logic [`GBF_ADDR_BITS-1:0] addr_w,
    input  gbf_pkg::gbf_word_u        data_in,
    output gbf_pkg::gbf_word_u        data_out
);

    // **********************************************************************
    // Single-address storage array
    // **********************************************************************
    logic [`GBF_WORD_BITS-1:0] mem [0:`GBF_DEPTH-1];
    logic [`GBF_ADDR_BITS-1:0] addr;

    // One shared address port, write wins
    assign addr = write_en ? addr_w : addr_r;

    // Write path
    always_ff @(posedge clk) begin
        if (write_en) begin
            mem[addr] <= data_in.raw;
        end
    end

    // Read path
    // Output register only loads on a read, otherwise keeps last word
    // No read while a write owns the address
    always_ff @(posedge clk) begin
        if (read_en && !write_en) begin
            data_out.raw <= mem[addr];
        end
    end

endmodule

//--- source/gbf_apb_slave.sv
`timescale 1ns/1ns
`include "gbf_defines.svh"

module gbf_apb_slave (
    input  logic                          clk,
    input  logic                          rst_n,
    // APB slave side
    input  logic [`GBF_APB_ADDR_BITS-1:0] paddr,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [31:0]                   pwdata,
    output logic [31:0]                   prdata,
    output logic                          pready,
    output logic                          pslverr,
    // Status from decoder and stream
    input  gbf_pkg::gbf_status_s          status,
    input  logic                          stream_empty,
    // Buffer write port
    output logic                          buf_write_en,
    output logic [`GBF_ADDR_BITS-1:0]     buf_addr,
    output gbf_pkg::gbf_word_u            buf_data,
    // Run control
    output logic                          start,
    output logic [`GBF_ADDR_BITS-1:0]     word_count
);

    logic access;
    logic hit_ctrl;
    logic hit_status;
    logic hit_buf;
    logic busy;
    logic start_req;

    // **********************************************************************
    // Address decode
    // **********************************************************************
    // Zero wait states
    assign pready = 1'b1;
    assign access = psel & penable;

    assign hit_ctrl   = (paddr == `GBF_REG_CTRL);
    assign hit_status = (paddr == `GBF_REG_STATUS);
    // Window of 64 aligned words above the base
    assign hit_buf = ((paddr >> (`GBF_ADDR_BITS + 2)) ==
                      (`GBF_BUF_BASE >> (`GBF_ADDR_BITS + 2))) &&
                     (paddr[1:0] == 2'b00);

    // Run in flight, includes start pulse and undrained stream
    assign busy = status.busy | ~stream_empty | start;

    // **********************************************************************
    // Buffer write, same cycle as the access phase
    // **********************************************************************
    assign buf_write_en  = access & pwrite & hit_buf & ~busy;
    assign buf_addr      = paddr[`GBF_ADDR_BITS+1:2];
    assign buf_data.raw  = pwdata[`GBF_WORD_BITS-1:0];

    // CTRL bit 0 starts, bits 6..1 hold word count minus one
    assign start_req = access & pwrite & hit_ctrl & pwdata[0] & ~busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start      <= 1'b0;
            word_count <= '0;
        end else begin
            // One-cycle pulse
            start <= start_req;
            if (start_req) begin
                word_count <= pwdata[`GBF_ADDR_BITS:1];
            end
        end
    end

    // **********************************************************************
    // Read data and error response
    // **********************************************************************
    always_comb begin
        prdata  = '0;
        pslverr = 1'b0;
        if (access) begin
            if (pwrite) begin
                if (hit_buf) begin
                    pslverr = busy;
                end else if (hit_ctrl) begin
                    // Refused start only
                    pslverr = pwdata[0] & busy;
                end else begin
                    pslverr = 1'b1;
                end
            end else if (hit_status) begin
                prdata = {24'd0, busy, status.count};
            end else begin
                pslverr = 1'b1;
            end
        end
    end

endmodule

//--- source/gbf_flag_decoder.sv
`timescale 1ns/1ns
`include "gbf_defines.svh"

module gbf_flag_decoder (
    input  logic                      clk,
    input  logic                      rst_n,
    // Run control from register block
    input  logic                      start,
    input  logic [`GBF_ADDR_BITS-1:0] word_count,
    // Buffer read port
    output logic                      rd_en,
    output logic [`GBF_ADDR_BITS-1:0] rd_addr,
    input  gbf_pkg::gbf_word_u        rd_data,
    // Weight push to stream
    output logic                      push_valid,
    output gbf_pkg::gbf_weight_s      push_data,
    input  logic                      push_ready,
    output gbf_pkg::gbf_status_s      status
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READ,
        ST_EMIT
    } state_t;

    state_t                    state;
    logic [`GBF_ADDR_BITS-1:0] word_idx;
    logic [`GBF_ADDR_BITS-1:0] last_idx;
    logic [2:0]                pending;
    logic [6:0]                count;
    logic [2:0]                active;
    logic [2:0]                lane_hot;
    logic [2:0]                remain;
    logic [1:0]                lane;
    logic                      push_fire;
    logic                      last_word;
    logic                      skip_word;

    // **********************************************************************
    // Lane pick
    // **********************************************************************
    // Flagged lanes not yet sent from the held word
    assign active = rd_data.fields.flags & pending;

    // Lowest lane first
    always_comb begin
        if (active[0]) begin
            lane     = 2'd0;
            lane_hot = 3'b001;
        end else if (active[1]) begin
            lane     = 2'd1;
            lane_hot = 3'b010;
        end else begin
            lane     = 2'd2;
            lane_hot = 3'b100;
        end
    end

    assign remain    = active & ~lane_hot;
    assign push_valid = (state == ST_EMIT) && (active != 3'b000);
    assign push_fire = push_valid & push_ready;
    assign last_word = (word_idx == last_idx);
    // Nothing flagged in this word
    assign skip_word = (state == ST_EMIT) && (active == 3'b000);

    assign push_data.weight = rd_data.fields.lanes[lane];
    assign push_data.pos    = 8'(word_idx) * 8'd3 + 8'(lane);

    // Read in READ, or straight away when an empty word is skipped
    assign rd_en   = (state == ST_READ) || (skip_word && !last_word);
    assign rd_addr = (state == ST_READ) ? word_idx : word_idx + 1'b1;

    assign status.busy  = (state != ST_IDLE);
    assign status.count = count;

    // **********************************************************************
    // Sequencer
    // **********************************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            word_idx <= '0;
            last_idx <= '0;
            pending  <= 3'b000;
            count    <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        word_idx <= '0;
                        last_idx <= word_count;
                        count    <= '0;
                        state    <= ST_READ;
                    end
                end
                ST_READ: begin
                    // Data lands next cycle, all lanes pending
                    pending <= 3'b111;
                    state   <= ST_EMIT;
                end
                ST_EMIT: begin
                    if (skip_word) begin
                        if (last_word) begin
                            state <= ST_IDLE;
                        end else begin
                            // Next read already issued this cycle
                            word_idx <= word_idx + 1'b1;
                            pending  <= 3'b111;
                        end
                    end else if (push_fire) begin
                        pending <= pending & ~lane_hot;
                        if (count != 7'h7f) begin
                            count <= count + 1'b1;
                        end
                        if (remain == 3'b000) begin
                            if (last_word) begin
                                state <= ST_IDLE;
                            end else begin
                                word_idx <= word_idx + 1'b1;
                                state    <= ST_READ;
                            end
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

//--- source/gbf_weight_stream.sv
`timescale 1ns/1ns

module gbf_weight_stream (
    input  logic                 clk,
    input  logic                 rst_n,
    // From decoder
    input  logic                 push_valid,
    input  gbf_pkg::gbf_weight_s push_data,
    output logic                 push_ready,
    // Output stream
    output logic                 out_valid,
    output gbf_pkg::gbf_weight_s out_data,
    input  logic                 out_ready,
    output logic                 empty
);

    // **********************************************************************
    // Two-entry skid storage
    // **********************************************************************
    gbf_pkg::gbf_weight_s entry [0:1];
    logic                 wr_ptr;
    logic                 rd_ptr;
    logic [1:0]           fill;
    logic [1:0]           fill_next;
    logic                 push;
    logic                 pop;

    assign push = push_valid & push_ready;
    assign pop  = out_valid & out_ready;

    assign fill_next = fill + {1'b0, push} - {1'b0, pop};

    // Head of queue
    assign out_valid = (fill != 2'd0);
    assign out_data  = entry[rd_ptr];
    assign empty     = (fill == 2'd0);

    // Payload only
    always_ff @(posedge clk) begin
        if (push) begin
            entry[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr     <= 1'b0;
            rd_ptr     <= 1'b0;
            fill       <= 2'd0;
            push_ready <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
            fill <= fill_next;
            // Registered ready, drops only with both entries full
            push_ready <= (fill_next != 2'd2);
        end
    end

endmodule

//--- source/gbf_top.sv
`timescale 1ns/1ns
`include "gbf_defines.svh"

module gbf_top (
    input  logic                          clk,
    input  logic                          rst_n,
    // APB slave
    input  logic [`GBF_APB_ADDR_BITS-1:0] paddr,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [31:0]                   pwdata,
    output logic [31:0]                   prdata,
    output logic                          pready,
    output logic                          pslverr,
    // Weight stream
    output logic                          out_valid,
    output gbf_pkg::gbf_weight_s          out_data,
    input  logic                          out_ready
);

    // **********************************************************************
    // Internal nets
    // **********************************************************************
    // Buffer write side
    logic                      buf_write_en;
    logic [`GBF_ADDR_BITS-1:0] buf_addr;
    gbf_pkg::gbf_word_u        buf_data;
    // Buffer read side
    logic                      rd_en;
    logic [`GBF_ADDR_BITS-1:0] rd_addr;
    gbf_pkg::gbf_word_u        rd_data;
    // Run control and status
    logic                      start;
    logic [`GBF_ADDR_BITS-1:0] word_count;
    gbf_pkg::gbf_status_s      status;
    logic                      stream_empty;
    // Decoder to stream
    logic                      push_valid;
    logic                      push_ready;
    gbf_pkg::gbf_weight_s      push_data;

    // Register block
    gbf_apb_slave u_apb (
        .clk          (clk),
        .rst_n        (rst_n),
        .paddr        (paddr),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .status       (status),
        .stream_empty (stream_empty),
        .buf_write_en (buf_write_en),
        .buf_addr     (buf_addr),
        .buf_data     (buf_data),
        .start        (start),
        .word_count   (word_count)
    );

    // Weight store
    gbf_weight_sram u_sram (
        .clk      (clk),
        .read_en  (rd_en),
        .write_en (buf_write_en),
        .addr_r   (rd_addr),
        .addr_w   (buf_addr),
        .data_in  (buf_data),
        .data_out (rd_data)
    );

    // Flag walk
    gbf_flag_decoder u_decoder (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .word_count (word_count),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .push_valid (push_valid),
        .push_data  (push_data),
        .push_ready (push_ready),
        .status     (status)
    );

    // Output decoupling
    gbf_weight_stream u_stream (
        .clk        (clk),
        .rst_n      (rst_n),
        .push_valid (push_valid),
        .push_data  (push_data),
        .push_ready (push_ready),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_ready  (out_ready),
        .empty      (stream_empty)
    );

endmodule

//--- tests/tb_gbf_checker.sv
`timescale 1ns/1ns

module tb_gbf_checker (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 out_valid,
    input logic                 out_ready,
    input gbf_pkg::gbf_weight_s out_data
);

    // Weights still owed by the DUT, oldest first
    gbf_pkg::gbf_weight_s exp_q[$];
    int error_count = 0;
    int test_count  = 0;
    int fail_count  = 0;
    int test_errors = 0;

    task automatic expect_weight(input gbf_pkg::gbf_weight_s w);
        exp_q.push_back(w);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic report_problem(input string what);
        $display("problem at %0t ns: %s", $time, what);
        error_count++;
        test_errors++;
    endtask

    // ******************************************************************
    // Stream monitor
    // ******************************************************************
    // Negedge sample, valid/ready/data settled for the next rising edge
    always @(negedge clk) begin
        if (rst_n && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                report_problem("the stream sent a weight that was not expected");
            end else begin
                check_value("out_data.weight", 32'(out_data.weight), 32'(exp_q[0].weight));
                check_value("out_data.pos", 32'(out_data.pos), 32'(exp_q[0].pos));
                void'(exp_q.pop_front());
            end
        end
    end

    // One line per test
    task automatic finish_test(input string name);
        if (exp_q.size() != 0) begin
            report_problem($sformatf("%0d expected weights never left the stream",
                                     exp_q.size()));
            exp_q.delete();
        end
        test_count++;
        if (test_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, test_errors);
            fail_count++;
        end
        test_errors = 0;
    endtask

    task automatic print_summary();
        $display("tests run %0d, tests failed %0d, errors %0d",
                 test_count, fail_count, error_count);
    endtask

endmodule

//--- tests/tb_gbf_top.sv
`timescale 1ns/1ns
`include "gbf_defines.svh"

module tb_gbf_top;

    localparam int APB_WAIT       = 16;
    localparam int IDLE_POLLS     = 600;
    localparam int FILL_RANDOM    = 0;
    localparam int FILL_NO_FLAGS  = 1;
    localparam int FILL_ALL_FLAGS = 2;

    logic                          clk;
    logic                          rst_n;
    logic [`GBF_APB_ADDR_BITS-1:0] paddr;
    logic                          psel;
    logic                          penable;
    logic                          pwrite;
    logic [31:0]                   pwdata;
    logic [31:0]                   prdata;
    logic                          pready;
    logic                          pslverr;
    logic                          out_valid;
    gbf_pkg::gbf_weight_s          out_data;
    logic                          out_ready;
    // Percent of cycles with out_ready high
    int unsigned                   ready_pct;
    // Model copy of the buffer
    logic [`GBF_WORD_BITS-1:0]     model_mem [0:`GBF_DEPTH-1];

    gbf_top DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_ready (out_ready)
    );

    tb_gbf_checker u_checker (
        .clk       (clk),
        .rst_n     (rst_n),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // Random back-pressure
    initial begin
        forever begin
            @(posedge clk);
            #1;
            if (ready_pct >= 100) begin
                out_ready = 1'b1;
            end else begin
                out_ready = ($urandom_range(99) < ready_pct);
            end
        end
    end

    task automatic abort_run(input string reason);
        u_checker.report_problem({"timeout: ", reason});
        $display(">>> FAIL");
        $finish;
    endtask

    // ******************************************************************
    // APB access with setup and access phase
    // ******************************************************************
    task automatic apb_access(input logic wr, input logic [11:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        int waited;
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;
        waited  = 0;
        @(negedge clk);
        // Zero wait states expected
        u_checker.check_value("pready", 32'(pready), 32'd1);
        while (!pready && waited < APB_WAIT) begin
            @(negedge clk);
            waited++;
        end
        if (!pready) begin
            abort_run("APB access never saw pready");
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic load_word(input int idx, input logic [27:0] word);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b1, 12'(`GBF_BUF_BASE + 4 * idx), {4'd0, word}, rdata, err);
        u_checker.check_value("pslverr", 32'(err), 32'd0);
        model_mem[idx] = word;
    endtask

    task automatic fill_buffer(input int mode);
        logic [27:0] word;
        for (int i = 0; i < `GBF_DEPTH; i++) begin
            word = 28'($urandom);
            if (mode == FILL_NO_FLAGS) begin
                word = word & ~28'h700_0000;
            end else if (mode == FILL_ALL_FLAGS) begin
                word = word | 28'h700_0000;
            end
            load_word(i, word);
        end
    endtask

    // ******************************************************************
    // Reference model
    // ******************************************************************
    // Flag k at bit 24+k keeps lane k
    // Position is word*3 + lane
    task automatic build_expected(input int n_words, output int n_kept);
        gbf_pkg::gbf_weight_s w;
        logic [27:0]          word;
        n_kept = 0;
        for (int i = 0; i < n_words; i++) begin
            word = model_mem[i];
            for (int k = 0; k < 3; k++) begin
                if (word[24 + k]) begin
                    w.weight = word[8 * k +: 8];
                    w.pos    = 8'(i * 3 + k);
                    u_checker.expect_weight(w);
                    n_kept++;
                end
            end
        end
    endtask

    function automatic int capped_count(input int n);
        return (n > 127) ? 127 : n;
    endfunction

    task automatic start_run(input int n_words);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b1, `GBF_REG_CTRL, 32'((n_words - 1) << 1) | 32'd1, rdata, err);
        u_checker.check_value("pslverr", 32'(err), 32'd0);
    endtask

    // Poll STATUS until busy drops
    task automatic wait_idle(output logic [31:0] status);
        int   polls;
        logic err;
        polls  = 0;
        status = 32'h80;
        while (status[7] && polls < IDLE_POLLS) begin
            apb_access(1'b0, `GBF_REG_STATUS, 32'd0, status, err);
            polls++;
        end
        if (status[7]) begin
            abort_run("run never finished, STATUS busy stayed high");
        end
    endtask

    task automatic check_run(input int n_words);
        int          n_kept;
        logic [31:0] status;
        build_expected(n_words, n_kept);
        start_run(n_words);
        wait_idle(status);
        u_checker.check_value("status.count", 32'(status[6:0]), 32'(capped_count(n_kept)));
    endtask

    // ******************************************************************
    // Test sequence
    // ******************************************************************
    initial begin
        logic [31:0] rdata;
        logic        err;
        int          n_kept;
        rst_n     = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        out_ready = 1'b0;
        ready_pct = 100;
        void'($urandom(54));
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Idle state and unmapped addresses
        apb_access(1'b0, `GBF_REG_STATUS, 32'd0, rdata, err);
        u_checker.check_value("prdata", rdata, 32'd0);
        u_checker.check_value("pslverr", 32'(err), 32'd0);
        repeat (8) begin
            @(negedge clk);
            u_checker.check_value("out_valid", 32'(out_valid), 32'd0);
        end
        apb_access(1'b0, 12'h008, 32'd0, rdata, err);
        u_checker.check_value("pslverr", 32'(err), 32'd1);
        u_checker.check_value("prdata", rdata, 32'd0);
        apb_access(1'b0, 12'hffc, 32'd0, rdata, err);
        u_checker.check_value("pslverr", 32'(err), 32'd1);
        apb_access(1'b1, 12'h040, 32'd5, rdata, err);
        u_checker.check_value("pslverr", 32'(err), 32'd1);
        u_checker.finish_test("reset_state");

        fill_buffer(FILL_RANDOM);
        check_run(64);
        u_checker.finish_test("full_run");

        // Same buffer under stalled output
        ready_pct = 40;
        check_run(64);
        u_checker.finish_test("back_pressure");

        ready_pct = 100;
        fill_buffer(FILL_NO_FLAGS);
        check_run(64);
        u_checker.finish_test("no_flags");

        fill_buffer(FILL_ALL_FLAGS);
        check_run(64);
        u_checker.finish_test("count_saturates");

        // Output blocked so the run stays busy
        fill_buffer(FILL_RANDOM);
        ready_pct = 0;
        build_expected(64, n_kept);
        start_run(64);
        apb_access(1'b1, 12'(`GBF_BUF_BASE + 20), {4'd0, ~model_mem[5]}, rdata, err);
        u_checker.check_value("pslverr", 32'(err), 32'd1);
        apb_access(1'b1, `GBF_REG_CTRL, 32'd1, rdata, err);
        u_checker.check_value("pslverr", 32'(err), 32'd1);
        ready_pct = 70;
        wait_idle(rdata);
        u_checker.check_value("status.count", 32'(rdata[6:0]), 32'(capped_count(n_kept)));
        u_checker.finish_test("busy_refusal");
        ready_pct = 100;
        check_run(64);
        u_checker.finish_test("buffer_unchanged");

        fill_buffer(FILL_RANDOM);
        repeat (6) begin
            ready_pct = $urandom_range(100, 30);
            check_run(int'($urandom_range(64, 1)));
        end
        u_checker.finish_test("random_counts");

        u_checker.print_summary();
        if (u_checker.error_count == 0 && u_checker.fail_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+source
source/gbf_pkg.sv
source/gbf_weight_sram.sv
source/gbf_apb_slave.sv
source/gbf_flag_decoder.sv
source/gbf_weight_stream.sv
source/gbf_top.sv
tests/tb_gbf_checker.sv
tests/tb_gbf_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the weight buffer testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

{ verilator --binary --timing --timescale 1ns/1ns -f verilog.f \
    --top-module tb_gbf_top -o tb_gbf_top \
    && ./obj_dir/tb_gbf_top; } > "$LOG" 2>&1 || echo "build or run returned an error"

cat "$LOG"

grep -qx '>>> PASS' "$LOG" \
    && echo "simulation passed" \
    || { echo "simulation failed, see $LOG"; exit 1; }
